// File: logic/board_pkg.sv
package board_pkg;

  // one uart byte, one led column pattern, the accumulator
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;  // instruction or received pair
  typedef logic [9:0]  addr_t;  // 1024 program words

  // opcode lives in bits 15..12 of a word
  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_ldi  = 4'h1,  // reg0 = imm
    op_addi = 4'h2,  // reg0 += imm, wraps
    op_xori = 4'h3,  // reg0 ^= imm
    op_out  = 4'h4   // reg0 to uart tx
  } opcode_t;

  // ff ff closes a program
  localparam word_t end_word = 16'hffff;

  // row 0 marker
  localparam byte_t row_marker = 8'b10101010;

endpackage

// File: logic/uart_link.sv
`timescale 1ns/1ps

module uart_link #(
  parameter int clks_per_bit = 234
) (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  logic             rx,
  output logic             tx,
  output board_pkg::byte_t rx_byte,
  output logic             rx_strobe,
  input  board_pkg::byte_t tx_byte,
  input  logic             tx_strobe,
  output logic             tx_busy
);
  import board_pkg::*;

  localparam int cw = $clog2(clks_per_bit);
  localparam logic [cw-1:0] bit_last  = cw'(clks_per_bit - 1);
  localparam logic [cw-1:0] half_last = cw'((clks_per_bit - 1) / 2);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_t;
  typedef enum logic [1:0] {tx_idle, tx_start, tx_bits, tx_stop} tx_state_t;

  rx_state_t       rx_state;
  logic [1:0]      rx_sync;   // metastability guard
  logic [cw-1:0]   rx_cnt;
  logic [2:0]      rx_bit;
  byte_t           rx_shift;

  tx_state_t       tx_state;
  logic [cw-1:0]   tx_cnt;
  logic [2:0]      tx_bit;
  byte_t           tx_shift;

  assign rx_byte = rx_shift;  // stable until next frame
  assign tx_busy = (tx_state != tx_idle);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync   <= 2'b11;  // line idles high
      rx_state  <= rx_idle;
      rx_cnt    <= '0;
      rx_bit    <= '0;
      rx_shift  <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_sync   <= {rx_sync[0], rx};
      rx_strobe <= 1'b0;
      case (rx_state)
        rx_idle: begin
          rx_cnt <= '0;
          if (!rx_sync[1]) rx_state <= rx_start;  // falling edge
        end
        rx_start: begin
          if (rx_cnt == half_last) begin
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_state <= rx_sync[1] ? rx_idle : rx_bits;  // high again means a glitch
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        rx_bits: begin
          if (rx_cnt == bit_last) begin
            rx_cnt   <= '0;
            rx_shift <= {rx_sync[1], rx_shift[7:1]};  // lsb first
            rx_bit   <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) rx_state <= rx_stop;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (rx_cnt == bit_last) begin
            rx_state  <= rx_idle;
            rx_strobe <= rx_sync[1];  // bad stop bit drops the frame
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        default: rx_state <= rx_idle;
      endcase
    end
  end

  // transmit side, tx is a flop so the line never glitches
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx       <= 1'b1;
      tx_state <= tx_idle;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx_shift <= '0;
    end else begin
      case (tx_state)
        tx_idle: begin
          tx_cnt <= '0;
          if (tx_strobe) begin
            tx_shift <= tx_byte;
            tx       <= 1'b0;  // start bit
            tx_state <= tx_start;
          end
        end
        tx_start: begin
          if (tx_cnt == bit_last) begin
            tx_cnt   <= '0;
            tx_bit   <= '0;
            tx       <= tx_shift[0];
            tx_state <= tx_bits;
          end else begin
            tx_cnt <= tx_cnt + 1'b1;
          end
        end
        tx_bits: begin
          if (tx_cnt == bit_last) begin
            tx_cnt   <= '0;
            tx_bit   <= tx_bit + 1'b1;
            tx_shift <= tx_shift >> 1;
            if (tx_bit == 3'd7) begin
              tx       <= 1'b1;  // stop bit
              tx_state <= tx_stop;
            end else begin
              tx <= tx_shift[1];
            end
          end else begin
            tx_cnt <= tx_cnt + 1'b1;
          end
        end
        tx_stop: begin
          if (tx_cnt == bit_last) tx_state <= tx_idle;  // busy ends here
          else tx_cnt <= tx_cnt + 1'b1;
        end
        default: tx_state <= tx_idle;
      endcase
    end
  end

endmodule

// File: logic/program_loader.sv
`timescale 1ns/1ps

module program_loader (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  board_pkg::byte_t rx_byte,
  input  logic             rx_strobe,
  output logic             wr_en,
  output board_pkg::addr_t wr_addr,
  output board_pkg::word_t wr_data,
  output board_pkg::word_t recv_word,
  output board_pkg::addr_t word_count,
  output logic             prog_done
);
  import board_pkg::*;

  logic  phase;      // 0 waits for high byte, 1 for low byte
  word_t next_word;  // recv_word once this byte lands

  assign next_word  = {recv_word[7:0], rx_byte};
  assign wr_data    = recv_word;  // wr_en trails the pair by one cycle
  assign word_count = wr_addr;    // words written so far

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= 1'b0;
      recv_word <= '0;
      wr_en     <= 1'b0;
      wr_addr   <= '0;
      prog_done <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (wr_en) wr_addr <= wr_addr + 1'b1;  // step after each write
      if (rx_strobe) begin
        recv_word <= next_word;
        if (prog_done) begin
          // new program starts, this byte is its first high byte
          prog_done <= 1'b0;
          phase     <= 1'b1;
          wr_addr   <= '0;
        end else begin
          phase <= ~phase;
          if (phase) begin
            if (next_word == end_word) prog_done <= 1'b1;  // terminator, not stored
            else wr_en <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: logic/program_ram.sv
`timescale 1ns/1ps

module program_ram (
  input  logic             sys_clk,
  input  logic             wr_en,
  input  board_pkg::addr_t wr_addr,
  input  board_pkg::word_t wr_data,
  input  board_pkg::addr_t rd_addr,
  output board_pkg::word_t rd_data
);
  import board_pkg::*;

  word_t mem [1024];  // maps to block ram

  // write port from the loader
  always_ff @(posedge sys_clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
  end

  // read port for the cpu, one cycle latency
  always_ff @(posedge sys_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: logic/tiny_cpu.sv
`timescale 1ns/1ps

module tiny_cpu (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  logic             prog_done,
  input  board_pkg::addr_t word_count,
  output board_pkg::addr_t rd_addr,
  input  board_pkg::word_t rd_data,
  output board_pkg::byte_t reg0,
  output board_pkg::byte_t tx_byte,
  output logic             tx_strobe,
  input  logic             tx_busy
);
  import board_pkg::*;

  addr_t   pc;          // next address to fetch
  logic    exec_valid;  // rd_data holds the word at pc - 1
  byte_t   acc;
  opcode_t op;
  byte_t   imm;
  logic    exec_on;
  logic    stall;       // out waiting for the transmitter

  assign op      = opcode_t'(rd_data[15:12]);
  assign imm     = rd_data[7:0];
  assign exec_on = prog_done && exec_valid;
  assign stall   = exec_on && (op == op_out) && tx_busy;

  // on a stall re-read the held word so rd_data keeps it
  assign rd_addr = stall ? pc - 1'b1 : pc;

  assign reg0      = prog_done ? acc : 8'h00;  // zero while loading
  assign tx_byte   = acc;
  assign tx_strobe = exec_on && (op == op_out) && !tx_busy;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= '0;
      exec_valid <= 1'b0;
    end else if (!prog_done) begin
      pc         <= '0;  // parked until a program is complete
      exec_valid <= 1'b0;
    end else if (!stall) begin
      exec_valid <= (pc < word_count);
      if (pc < word_count) pc <= pc + 1'b1;
    end
  end

  // execute stage
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (!prog_done) begin
      acc <= '0;
    end else if (exec_on && !stall) begin
      case (op)
        op_ldi:  acc <= imm;
        op_addi: acc <= acc + imm;  // mod 256
        op_xori: acc <= acc ^ imm;
        default: acc <= acc;        // nop, out and unused codes
      endcase
    end
  end

endmodule

// File: logic/led_matrix_scan.sv
`timescale 1ns/1ps

module led_matrix_scan #(
  parameter int scan_period = 27000,
  parameter int scan_gap    = 500
) (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  board_pkg::byte_t reg0,
  input  board_pkg::word_t recv_word,
  output board_pkg::byte_t led_col,
  output logic [8:0]       led_row
);
  import board_pkg::*;

  localparam int cw = $clog2(scan_period);
  localparam logic [cw-1:0] cnt_last = cw'(scan_period - 1);
  localparam logic [cw-1:0] on_lo    = cw'(scan_gap);
  localparam logic [cw-1:0] on_hi    = cw'(scan_period - scan_gap);

  logic [cw-1:0] counter;    // cycles inside the current row
  logic [2:0]    row_index;
  logic          led_on;

  // dark at both ends so neighbouring rows never ghost
  assign led_on  = (counter >= on_lo) && (counter < on_hi);
  assign led_row = led_on ? (9'd1 << row_index) : 9'd0;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      counter   <= '0;
      row_index <= '0;
    end else if (counter == cnt_last) begin
      counter   <= '0;
      row_index <= row_index + 1'b1;  // wraps at 8
    end else begin
      counter <= counter + 1'b1;
    end
  end

  always_comb begin
    case (row_index)
      3'd0:    led_col = row_marker;
      3'd1:    led_col = reg0;
      3'd2:    led_col = recv_word[15:8];
      3'd3:    led_col = recv_word[7:0];
      default: led_col = 8'h00;  // rows 4..7 unused
    endcase
  end

endmodule

// File: logic/board_top.sv
`timescale 1ns/1ps

module board_top #(
  parameter int clks_per_bit = 234,
  parameter int scan_period  = 27000,
  parameter int scan_gap     = 500
) (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  logic             uart_rx,
  output logic             uart_tx,
  output board_pkg::byte_t led_col,
  output logic [8:0]       led_row
);
  import board_pkg::*;

  byte_t rx_byte;
  logic  rx_strobe;
  byte_t tx_byte;
  logic  tx_strobe;
  logic  tx_busy;
  logic  wr_en;
  addr_t wr_addr;
  word_t wr_data;
  word_t recv_word;  // last two bytes, also shown on rows 2 and 3
  addr_t word_count;
  logic  prog_done;
  addr_t rd_addr;
  word_t rd_data;
  byte_t reg0;

  uart_link #(.clks_per_bit(clks_per_bit)) u_uart_link (
    .sys_clk, .rst_n,
    .rx(uart_rx), .tx(uart_tx),
    .rx_byte, .rx_strobe,
    .tx_byte, .tx_strobe, .tx_busy
  );

  program_loader u_program_loader (
    .sys_clk, .rst_n,
    .rx_byte, .rx_strobe,
    .wr_en, .wr_addr, .wr_data,
    .recv_word, .word_count, .prog_done
  );

  program_ram u_program_ram (
    .sys_clk,
    .wr_en, .wr_addr, .wr_data,
    .rd_addr, .rd_data
  );

  tiny_cpu u_tiny_cpu (
    .sys_clk, .rst_n,
    .prog_done, .word_count,
    .rd_addr, .rd_data,
    .reg0,
    .tx_byte, .tx_strobe, .tx_busy
  );

  led_matrix_scan #(.scan_period(scan_period), .scan_gap(scan_gap)) u_led_matrix_scan (
    .sys_clk, .rst_n,
    .reg0, .recv_word,
    .led_col, .led_row
  );

endmodule

// File: sim/board_top_checker.sv
`timescale 1ns/1ps

module board_top_checker (
  input logic             sys_clk,
  input logic             rst_n,
  input logic [8:0]       led_row,
  input logic             tx_strobe,
  input logic             tx_busy,
  input board_pkg::byte_t reg0,
  input logic             prog_done
);

  int fails;

  // at most one row lit
  row_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(led_row))
    else begin
      $error("led_row %09b has more than one row lit", led_row);
      fails++;
    end

  // transmitter takes a byte only when idle
  strobe_idle: assert property (@(posedge sys_clk) disable iff (!rst_n) !(tx_strobe && tx_busy))
    else begin
      $error("tx_strobe while tx_busy");
      fails++;
    end

  // cpu parked while loading
  reg0_parked: assert property (@(posedge sys_clk) disable iff (!rst_n) !prog_done |-> reg0 == 8'h00)
    else begin
      $error("reg0 %02h while prog_done low", reg0);
      fails++;
    end

endmodule

// File: sim/board_top_monitor.sv
`timescale 1ns/1ps

module board_top_monitor #(
  parameter int clks_per_bit = 8,
  parameter int scan_gap     = 8
) (
  input logic             sys_clk,
  input logic             rst_n,
  input logic             uart_tx,
  input board_pkg::byte_t led_col,
  input logic [8:0]       led_row
);
  import board_pkg::*;

  byte_t      exp_q[$];    // out bytes still to arrive
  byte_t      model_acc;   // model reg0
  int         pending;
  int         errors;
  int         test_errors;
  int         tests;
  int         dark_run;
  logic [8:0] last_row;

  task automatic model_reset();
    model_acc = 8'h00;
  endtask

  // opcode in bits 15..12
  task automatic model_word(input word_t w);
    case (w[15:12])
      4'h1: model_acc = w[7:0];              // ldi
      4'h2: model_acc = model_acc + w[7:0];  // addi, wraps at 256
      4'h3: model_acc = model_acc ^ w[7:0];  // xori
      4'h4: begin
        exp_q.push_back(model_acc);          // out
        pending++;
      end
      default: ;                             // nop and unused codes
    endcase
  endtask

  task automatic mismatch(input string sig, input logic [15:0] exp, input logic [15:0] act);
    $display("FAILED t=%0t %s expected %0h got %0h", $time, sig, exp, act);
    errors++;
    test_errors++;
  endtask

  task automatic complain(input string what);
    $display("error at t=%0t: %s", $time, what);
    errors++;
    test_errors++;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (test_errors == 0) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, test_errors);
    test_errors = 0;
  endtask

  // tx idle and rows dark through the first gap
  task automatic check_reset_idle();
    repeat (scan_gap) begin
      @(negedge sys_clk);
      if (uart_tx !== 1'b1) mismatch("uart_tx", 16'h0001, {15'd0, uart_tx});
      if (led_row !== 9'd0) mismatch("led_row", 16'h0000, {7'd0, led_row});
    end
  endtask

  // rows 0..7, each compared the first time it lights
  task automatic check_rows();
    logic [7:0] seen;
    byte_t      want [8];
    seen = 8'h00;
    // recv_word is ffff after a load, rows 4..7 stay dark
    want = '{8'b10101010, model_acc, 8'hff, 8'hff, 8'h00, 8'h00, 8'h00, 8'h00};
    while (seen != 8'hff) begin
      @(negedge sys_clk);
      for (int r = 0; r < 8; r++) begin
        if (led_row == (9'd1 << r) && !seen[r]) begin
          seen[r] = 1'b1;
          if (led_col !== want[r]) begin
            mismatch($sformatf("led_col row %0d", r), {8'd0, want[r]}, {8'd0, led_col});
          end
        end
      end
    end
  endtask

  // dark gap and row order at each row change
  always @(negedge sys_clk) begin
    if (!rst_n) begin
      dark_run = 0;
      last_row = 9'd0;
    end else if (led_row == 9'd0) begin
      dark_run++;
    end else begin
      if (last_row != 9'd0 && led_row != last_row) begin
        if (dark_run != 2 * scan_gap) begin
          complain($sformatf("row change after %0d dark cycles", dark_run));
        end
        if (led_row != {1'b0, last_row[6:0], last_row[7]}) complain("led rows out of order");
      end
      dark_run = 0;
      last_row = led_row;
    end
  end

  // serial decode of uart_tx, sampled mid bit
  initial begin
    byte_t got;
    @(posedge rst_n);
    forever begin
      @(negedge sys_clk);
      if (uart_tx == 1'b0) begin
        repeat (clks_per_bit / 2) @(negedge sys_clk);  // middle of start bit
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(negedge sys_clk);
          got[i] = uart_tx;
        end
        repeat (clks_per_bit) @(negedge sys_clk);
        if (uart_tx !== 1'b1) complain("stop bit low on uart_tx");
        if (exp_q.size() == 0) begin
          complain($sformatf("unexpected byte %02h on uart_tx", got));
        end else begin
          if (got !== exp_q[0]) mismatch("uart_tx byte", {8'd0, exp_q[0]}, {8'd0, got});
          void'(exp_q.pop_front());
          pending--;
        end
      end
    end
  end

endmodule

// File: sim/board_top_tb.sv
`timescale 1ns/1ps

module board_top_tb;
  import board_pkg::*;

  localparam int clks_per_bit = 8;
  localparam int scan_period  = 64;
  localparam int scan_gap     = 8;
  localparam int num_progs    = 3;  // first load then two reloads

  logic        sys_clk;
  logic        rst_n;
  logic        uart_rx;
  logic        uart_tx;
  byte_t       led_col;
  logic [8:0]  led_row;

  logic [31:0] lfsr;
  word_t       progs [num_progs][12];
  int          lens [num_progs];
  int          cycles = 0;
  int          cycle_limit = 1000000;

  board_top #(
    .clks_per_bit(clks_per_bit),
    .scan_period(scan_period),
    .scan_gap(scan_gap)
  ) u_board_top (
    .sys_clk, .rst_n,
    .uart_rx, .uart_tx,
    .led_col, .led_row
  );

  board_top_monitor #(.clks_per_bit(clks_per_bit), .scan_gap(scan_gap)) u_monitor (
    .sys_clk, .rst_n, .uart_tx, .led_col, .led_row
  );

  bind board_top board_top_checker u_checker (
    .sys_clk, .rst_n, .led_row, .tx_strobe, .tx_busy, .reg0, .prog_done
  );

  initial sys_clk = 1'b0;
  always #5 sys_clk = ~sys_clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v = (v << 1) | {31'd0, lfsr[0]};
    end
  endtask

  task automatic make_program(input int p);
    int n;
    int op;
    int imm;
    take_bits(4, n);
    lens[p] = 4 + n % 9;  // 4..12 words
    for (int i = 0; i < lens[p]; i++) begin
      take_bits(3, op);
      take_bits(8, imm);
      progs[p][i] = {4'(op % 5), 4'h0, imm[7:0]};  // nop ldi addi xori out
    end
    // back to back outs, second one meets tx_busy
    progs[p][lens[p] - 2][15:12] = op_out;
    progs[p][lens[p] - 1][15:12] = op_out;
  endtask

  task automatic drive_bit(input logic v);
    @(posedge sys_clk);
    #1 uart_rx = v;
    repeat (clks_per_bit - 1) @(posedge sys_clk);
  endtask

  // 8n1, lsb first
  task automatic send_byte(input byte_t b);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(b[i]);
    drive_bit(1'b1);
  endtask

  always @(posedge sys_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout, run still busy after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    int    sent;
    int    outs;
    string name;
    rst_n   = 1'b0;
    uart_rx = 1'b1;  // line idle
    lfsr    = 32'hd2500ed1;
    sent    = 0;
    outs    = 0;
    for (int p = 0; p < num_progs; p++) begin
      make_program(p);
      sent += 2 * lens[p] + 2;  // words plus ff ff
      for (int i = 0; i < lens[p]; i++) begin
        if (progs[p][i][15:12] == op_out) outs++;
      end
    end
    // 10 bit times per byte each way, row scans and reset gap on top
    cycle_limit = (sent + outs) * 10 * clks_per_bit + num_progs * 16 * scan_period + 1000;
    repeat (3) @(posedge sys_clk);
    #1 rst_n = 1'b1;
    u_monitor.check_reset_idle();
    u_monitor.end_test("reset idle");
    for (int p = 0; p < num_progs; p++) begin
      u_monitor.model_reset();
      for (int i = 0; i < lens[p]; i++) u_monitor.model_word(progs[p][i]);
      for (int i = 0; i < lens[p]; i++) begin
        send_byte(progs[p][i][15:8]);  // high byte first
        send_byte(progs[p][i][7:0]);
      end
      send_byte(8'hff);
      send_byte(8'hff);
      while (u_monitor.pending != 0) @(posedge sys_clk);  // last out is the last word
      u_monitor.check_rows();
      if (p == 0) name = "first load";
      else name = $sformatf("reload %0d", p);
      u_monitor.end_test(name);
    end
    $display("%0d tests, %0d errors, %0d assertion failures",
             u_monitor.tests, u_monitor.errors, u_board_top.u_checker.fails);
    if (u_monitor.errors == 0 && u_board_top.u_checker.fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: uart_loader_board.f
logic/board_pkg.sv
logic/uart_link.sv
logic/program_loader.sv
logic/program_ram.sv
logic/tiny_cpu.sv
logic/led_matrix_scan.sv
logic/board_top.sv
sim/board_top_checker.sv
sim/board_top_monitor.sv
sim/board_top_tb.sv

// File: Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= board_top_tb
FILELIST  ?= uart_loader_board.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
